//--- pkt_rx_top.f
logic/pkt_rx_pkg.sv
logic/pkt_header_tagger.sv
logic/axis_packer.sv
logic/header_decoder.sv
logic/pkt_rx_top.sv
tests/tb_clock.sv
tests/pkt_rx_tb.sv

//--- Makefile
# Verilator build and run of the receive path testbench.

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
		--top-module pkt_rx_tb -f pkt_rx_top.f
	./obj_dir/Vpkt_rx_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/pkt_rx_tb.sv
// Testbench for the receive path; sends random packets and checks payload, header and decode.

`timescale 1ns/1ps

module pkt_rx_tb;

	logic clk;
	logic rst_n;
	logic in_tvalid;
	logic in_tlast;
	logic [31:0] in_tdata;
	logic [3:0] in_tkeep;
	logic in_tready;
	logic out_tvalid;
	logic out_tlast;
	logic [31:0] out_tdata;
	logic [3:0] out_tkeep;
	logic out_tready;
	pkt_rx_pkg::hdr_u hdr;
	logic meta_valid;
	logic is_route;
	logic kind_unknown;
	logic [7:0] dest;
	logic [15:0] flow_id;
	logic [7:0] opcode;
	logic [31:0] arg;
	logic len_error;

	integer seed;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	bit timed_out = 1'b0;
	bit stall_en = 1'b0;
	bit sink_hold = 1'b0;

	// Model state per packet, written by the generator. The run uses 220 packets.
	logic [47:0] hdr_word [256];
	int pay_len [256];
	bit len_bad [256];
	int pkts_built = 0;
	logic [7:0] exp_bytes [$];
	logic [7:0] pkt_bytes [$];

	// Where the monitor stands on the input and output links.
	int in_word = 0;
	int in_pkt = 0;
	int out_pkt = 0;
	int out_off = 0;
	bit meta_pend = 1'b0;
	int meta_idx = 0;
	bit len_exp = 1'b0;

	tb_clock tb_clock_inst (.clk(clk));

	pkt_rx_top pkt_rx_top_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.in_tvalid(in_tvalid),
		.in_tlast(in_tlast),
		.in_tdata(in_tdata),
		.in_tkeep(in_tkeep),
		.in_tready(in_tready),
		.out_tvalid(out_tvalid),
		.out_tlast(out_tlast),
		.out_tdata(out_tdata),
		.out_tkeep(out_tkeep),
		.out_tready(out_tready),
		.hdr(hdr),
		.meta_valid(meta_valid),
		.is_route(is_route),
		.kind_unknown(kind_unknown),
		.dest(dest),
		.flow_id(flow_id),
		.opcode(opcode),
		.arg(arg),
		.len_error(len_error)
	);

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// ------------------------------------------------------------------------
	// Packet generator and input driver.
	// ------------------------------------------------------------------------

	// Kind 0 is route, 1 is control and 2 is an unknown kind byte.
	task automatic make_packet(input int n, input int kind, input bit bad);
		logic [47:0] h;
		logic [7:0] b;
		h[31:0] = $random(seed);
		h[47:32] = 16'($random(seed));
		if (kind == 0)
		begin
			h[7:0] = pkt_rx_pkg::kind_route;
			h[47:32] = bad ? 16'(n + 1 + ($random(seed) & 15)) : 16'(n);
		end
		else if (kind == 1)
			h[7:0] = pkt_rx_pkg::kind_ctrl;
		else
			h[7:0] = 8'h03 + 8'($random(seed) & 8'h7f);
		hdr_word[pkts_built] = h;
		pay_len[pkts_built] = n;
		len_bad[pkts_built] = (kind == 0) && bad;
		pkt_bytes.delete();
		for (int i = 0; i < 6; i++)
			pkt_bytes.push_back(h[i*8 +: 8]);
		for (int i = 0; i < n; i++)
		begin
			b = 8'($random(seed));
			pkt_bytes.push_back(b);
			exp_bytes.push_back(b);
		end
		pkts_built++;
	endtask

	// Called just after a rising edge; returns in the same position.
	task automatic send_packet(input bit gaps);
		int nwords;
		int cycles;
		nwords = (pkt_bytes.size() + 3) / 4;
		for (int w = 0; w < nwords; w++)
		begin
			if (gaps && (($random(seed) & 3) == 0))
			begin
				in_tvalid = 1'b0;
				repeat (1 + ($random(seed) & 1)) @(posedge clk);
				#1;
			end
			in_tvalid = 1'b1;
			in_tlast = (w == nwords - 1);
			for (int l = 0; l < 4; l++)
			begin
				in_tkeep[l] = (w * 4 + l) < pkt_bytes.size();
				in_tdata[l*8 +: 8] = in_tkeep[l] ? pkt_bytes[w*4+l] : 8'h00;
			end
			cycles = 0;
			@(negedge clk);
			while (!in_tready && cycles < 200)
			begin
				@(negedge clk);
				cycles++;
			end
			if (!in_tready)
			begin
				$display("timeout: in_tready stayed low for 200 cycles on packet %0d",
					pkts_built - 1);
				timed_out = 1'b1;
				errors++;
				break;
			end
			@(posedge clk);
			#1;
		end
		in_tvalid = 1'b0;
		in_tlast = 1'b0;
	endtask

	// Random sink stalls, a quarter of the cycles when enabled.
	always
	begin
		@(posedge clk);
		#1;
		if (sink_hold)
			out_tready = 1'b0;
		else
			out_tready = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
	end

	// ------------------------------------------------------------------------
	// Monitor, sampled at the falling edge where every signal is settled.
	// ------------------------------------------------------------------------

	task automatic verify_decode(input int idx);
		logic [47:0] h;
		bit route;
		h = hdr_word[idx];
		route = h[7:0] == pkt_rx_pkg::kind_route;
		check_value("meta_valid", meta_valid, 1);
		check_value("hdr", hdr, h);
		check_value("is_route", is_route, route);
		check_value("kind_unknown", kind_unknown, !route && h[7:0] != pkt_rx_pkg::kind_ctrl);
		check_value("dest", dest, route ? h[15:8] : 8'h00);
		check_value("flow_id", flow_id, route ? h[31:16] : 16'h0000);
		check_value("opcode", opcode, route ? 8'h00 : h[15:8]);
		check_value("arg", arg, route ? 32'h0 : h[47:16]);
	endtask

	task automatic score_out_beat();
		int remaining;
		int n;
		logic [3:0] keep;
		bit last;
		if (out_pkt >= pkts_built)
		begin
			errors++;
			$display("output beat at %0t with no packet outstanding", $time);
		end
		else
		begin
			remaining = pay_len[out_pkt] - out_off;
			n = (remaining > 4) ? 4 : remaining;
			keep = 4'((1 << n) - 1);
			last = remaining <= 4;
			check_value("meta_valid", meta_valid, 1);
			check_value("out_tlast", out_tlast, last);
			check_value("out_tkeep", out_tkeep, keep);
			for (int l = 0; l < n; l++)
				check_value("out_tdata", out_tdata[l*8 +: 8], exp_bytes.pop_front());
			out_off += n;
			if (last)
			begin
				check_value("is_route", is_route, hdr_word[out_pkt][7:0] == pkt_rx_pkg::kind_route);
				len_exp = len_bad[out_pkt];
				out_pkt++;
				out_off = 0;
			end
		end
	endtask

	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			in_word = 0;
			meta_pend = 1'b0;
			len_exp = 1'b0;
		end
		else
		begin
			// The pulse expected here was set by last cycle's tlast beat.
			check_value("len_error", len_error, len_exp);
			len_exp = 1'b0;
			if (meta_pend)
				verify_decode(meta_idx);
			meta_pend = 1'b0;
			if (in_tvalid && in_tready)
			begin
				if (in_word == 1)
				begin
					meta_pend = 1'b1;
					meta_idx = in_pkt;
				end
				in_word++;
				if (in_tlast)
				begin
					in_word = 0;
					in_pkt++;
				end
			end
			if (out_tvalid && out_tready)
				score_out_beat();
		end
	end

	// ------------------------------------------------------------------------
	// Test sequence.
	// ------------------------------------------------------------------------

	task automatic report_test(input string name, input int start);
		if (errors == start)
		begin
			tests_passed++;
			$display("test %s: pass", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: fail, %0d errors", name, errors - start);
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	task automatic reset_state_test(input string name);
		int start;
		start = errors;
		@(negedge clk);
		check_value("out_tvalid", out_tvalid, 0);
		check_value("meta_valid", meta_valid, 0);
		check_value("len_error", len_error, 0);
		check_value("in_tready", in_tready, 1);
		@(posedge clk);
		#1;
		report_test(name, start);
	endtask

	task automatic wait_drained(input string name);
		int cycles;
		cycles = 0;
		while (out_pkt < pkts_built && cycles < 2000)
		begin
			@(negedge clk);
			cycles++;
		end
		if (out_pkt < pkts_built)
		begin
			$display("timeout: only %0d of %0d packets came out during %s", out_pkt,
				pkts_built, name);
			timed_out = 1'b1;
			errors++;
		end
		// Leave room for the length check of the final packet.
		repeat (2) @(posedge clk);
		#1;
	endtask

	task automatic run_traffic(input string name, input int count, input bit random_mode);
		int start;
		int r;
		start = errors;
		stall_en = random_mode;
		for (int i = 0; i < count && !timed_out; i++)
		begin
			if (random_mode)
			begin
				r = $random(seed) & 3;
				make_packet(1 + int'($unsigned($random(seed)) % 19), (r == 3) ? 2 : (r == 2),
					($random(seed) & 3) == 0);
			end
			else
				make_packet(i % 19 + 1, i % 3, i % 2 == 0);
			send_packet(random_mode);
		end
		if (!timed_out)
			wait_drained(name);
		stall_en = 1'b0;
		report_test(name, start);
	endtask

	initial
	begin
		seed = 32'h4178c68a;
		rst_n = 1'b0;
		in_tvalid = 1'b0;
		in_tlast = 1'b0;
		in_tdata = '0;
		in_tkeep = '0;
		out_tready = 1'b1;
		apply_reset();
		reset_state_test("reset state");
		run_traffic("sizes 1 to 19 without stalls", 19, 1'b0);
		run_traffic("200 random packets with gaps and stalls", 200, 1'b1);
		if (!timed_out)
		begin
			// Park a short packet in the output register with the sink stalled,
			// so the reset below has live state to clear.
			sink_hold = 1'b1;
			make_packet(2, 0, 1'b0);
			send_packet(1'b0);
			apply_reset();
			sink_hold = 1'b0;
			reset_state_test("reset after traffic");
		end
		$display("tests passed: %0d, tests failed: %0d, check errors: %0d", tests_passed,
			tests_failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- tests/tb_clock.sv
// Free-running testbench clock with a 4 ns period, instantiated by the receive path testbench.

`timescale 1ns/1ps

module tb_clock
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

endmodule

//--- logic/pkt_rx_top.sv
// Receive path top level; tagger, packer and decoder joined by the internal payload link.

`timescale 1ns/1ps

module pkt_rx_top
(
	input logic clk,
	input logic rst_n,

	// Packet input.
	input logic in_tvalid,
	input logic in_tlast,
	input logic [pkt_rx_pkg::bus_bits-1:0] in_tdata,
	input logic [pkt_rx_pkg::bus_bytes-1:0] in_tkeep,
	output logic in_tready,

	// Packed payload output.
	output logic out_tvalid,
	output logic out_tlast,
	output logic [pkt_rx_pkg::bus_bits-1:0] out_tdata,
	output logic [pkt_rx_pkg::bus_bytes-1:0] out_tkeep,
	input logic out_tready,

	// Header and decoded fields.
	output pkt_rx_pkg::hdr_u hdr,
	output logic meta_valid,
	output logic is_route,
	output logic kind_unknown,
	output logic [7:0] dest,
	output logic [15:0] flow_id,
	output logic [7:0] opcode,
	output logic [31:0] arg,
	output logic len_error
);

	// -------------------------------------------------------------------------
	// Tagger to packer link.
	// -------------------------------------------------------------------------

	logic mid_tvalid;
	logic mid_tready;
	logic mid_tlast;
	logic [pkt_rx_pkg::bus_bits-1:0] mid_tdata;
	logic [pkt_rx_pkg::bus_bytes-1:0] mid_tkeep;

	pkt_header_tagger pkt_header_tagger_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.in_tvalid(in_tvalid),
		.in_tlast(in_tlast),
		.in_tdata(in_tdata),
		.in_tkeep(in_tkeep),
		.in_tready(in_tready),
		.mid_tvalid(mid_tvalid),
		.mid_tlast(mid_tlast),
		.mid_tdata(mid_tdata),
		.mid_tkeep(mid_tkeep),
		.mid_tready(mid_tready),
		.hdr(hdr)
	);

	axis_packer axis_packer_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.mid_tvalid(mid_tvalid),
		.mid_tlast(mid_tlast),
		.mid_tdata(mid_tdata),
		.mid_tkeep(mid_tkeep),
		.mid_tready(mid_tready),
		.out_tvalid(out_tvalid),
		.out_tlast(out_tlast),
		.out_tdata(out_tdata),
		.out_tkeep(out_tkeep),
		.out_tready(out_tready)
	);

	// The decoder only observes both links.
	header_decoder header_decoder_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.hdr(hdr),
		.mid_tvalid(mid_tvalid),
		.mid_tready(mid_tready),
		.mid_tkeep(mid_tkeep),
		.out_tvalid(out_tvalid),
		.out_tready(out_tready),
		.out_tlast(out_tlast),
		.out_tkeep(out_tkeep),
		.meta_valid(meta_valid),
		.is_route(is_route),
		.kind_unknown(kind_unknown),
		.dest(dest),
		.flow_id(flow_id),
		.opcode(opcode),
		.arg(arg),
		.len_error(len_error)
	);

endmodule

//--- logic/header_decoder.sv
// Decodes the side-bus header per packet as route or control and checks route payload lengths.

`timescale 1ns/1ps

module header_decoder
(
	input logic clk,
	input logic rst_n,

	input pkt_rx_pkg::hdr_u hdr,

	// Payload link into the packer, watched for the first beat.
	input logic mid_tvalid,
	input logic mid_tready,
	input logic [pkt_rx_pkg::bus_bytes-1:0] mid_tkeep,

	// Packed output link, watched for delivered bytes.
	input logic out_tvalid,
	input logic out_tready,
	input logic out_tlast,
	input logic [pkt_rx_pkg::bus_bytes-1:0] out_tkeep,

	output logic meta_valid,
	output logic is_route,
	output logic kind_unknown,
	output logic [7:0] dest,
	output logic [15:0] flow_id,
	output logic [7:0] opcode,
	output logic [31:0] arg,
	output logic len_error
);

	logic mid_first;
	logic out_fire;
	logic out_last_fire;
	logic cap_pend;
	pkt_rx_pkg::hdr_u hdr_q;
	pkt_rx_pkg::hdr_u view;
	logic [2:0] out_pop;
	logic [15:0] byte_cnt;
	logic [15:0] byte_sum;

	// The split word is the first payload beat. Header bytes 4 and 5 land in
	// hdr on that same edge, so the word is copied one cycle later and read
	// straight from hdr in between.
	assign mid_first = mid_tvalid && mid_tready
		&& (mid_tkeep[pkt_rx_pkg::hdr_lanes-1:0] == '0);
	assign view = cap_pend ? hdr : hdr_q;

	assign out_fire = out_tvalid && out_tready;
	assign out_last_fire = out_fire && out_tlast;

	always_comb
	begin
		out_pop = '0;
		for (int i = 0; i < pkt_rx_pkg::bus_bytes; i++)
			out_pop = out_pop + 3'(out_tkeep[i]);
	end

	assign byte_sum = byte_cnt + 16'(out_pop);

	// Unknown kinds decode as control.
	assign is_route = view.route.kind == pkt_rx_pkg::kind_route;
	assign kind_unknown = !is_route && (view.ctrl.kind != pkt_rx_pkg::kind_ctrl);
	assign dest = is_route ? view.route.dest : '0;
	assign flow_id = is_route ? view.route.flow_id : '0;
	assign opcode = is_route ? '0 : view.ctrl.opcode;
	assign arg = is_route ? '0 : view.ctrl.arg;

	always_ff @(posedge clk)
	begin
		if (cap_pend)
			hdr_q <= hdr;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cap_pend <= 1'b0;
			meta_valid <= 1'b0;
			byte_cnt <= '0;
			len_error <= 1'b0;
		end
		else
		begin
			cap_pend <= mid_first;
			len_error <= out_last_fire && is_route && (byte_sum != view.route.length);
			// A new packet can start on the edge that closes the previous one.
			if (mid_first)
				meta_valid <= 1'b1;
			else if (out_last_fire)
				meta_valid <= 1'b0;
			if (out_last_fire)
				byte_cnt <= '0;
			else if (out_fire)
				byte_cnt <= byte_sum;
		end
	end

	// Every beat on the output link belongs to a packet whose header is held.
	assert property (@(posedge clk) disable iff (!rst_n) out_tvalid |-> meta_valid);

endmodule

//--- logic/axis_packer.sv
// Realigns the tagger's payload stream so output beats start at lane 0 and only the last one is short.

`timescale 1ns/1ps

module axis_packer
(
	input logic clk,
	input logic rst_n,

	// Payload from the tagger. The split word has its low lanes cleared.
	input logic mid_tvalid,
	input logic mid_tlast,
	input logic [pkt_rx_pkg::bus_bits-1:0] mid_tdata,
	input logic [pkt_rx_pkg::bus_bytes-1:0] mid_tkeep,
	output logic mid_tready,

	// Packed output, registered.
	output logic out_tvalid,
	output logic out_tlast,
	output logic [pkt_rx_pkg::bus_bits-1:0] out_tdata,
	output logic [pkt_rx_pkg::bus_bytes-1:0] out_tkeep,
	input logic out_tready
);

	logic first_beat;
	logic [pkt_rx_pkg::bus_bits-1:0] in_masked;
	logic [pkt_rx_pkg::bus_bits-1:0] in_aligned;
	logic [2:0] in_cnt;
	logic [2:0] total;

	// Bytes carried over from the previous beat, packed at the low end.
	logic [pkt_rx_pkg::hdr_split_lanes*8-1:0] res;
	logic [pkt_rx_pkg::hdr_split_lanes*8-1:0] res_masked;
	logic [1:0] res_cnt;
	logic [pkt_rx_pkg::bus_bytes-1:0] res_keep;

	logic [(pkt_rx_pkg::bus_bytes+pkt_rx_pkg::hdr_split_lanes)*8-1:0] merged;
	logic [pkt_rx_pkg::bus_bytes-1:0] part_keep;

	// A tlast beat left more bytes than one word can hold.
	logic flush;
	logic out_free;

	assign out_free = !out_tvalid || out_tready;
	assign mid_tready = out_free && !flush;

	// The split word is the only beat whose low lanes are empty.
	assign first_beat = mid_tkeep[pkt_rx_pkg::hdr_lanes-1:0] == '0;

	// -------------------------------------------------------------------------
	// Lane merge.
	// -------------------------------------------------------------------------

	always_comb
	begin
		for (int i = 0; i < pkt_rx_pkg::bus_bytes; i++)
			in_masked[i*8 +: 8] = mid_tkeep[i] ? mid_tdata[i*8 +: 8] : 8'h00;

		in_aligned = first_beat ? (in_masked >> (pkt_rx_pkg::hdr_lanes * 8)) : in_masked;

		in_cnt = '0;
		for (int i = 0; i < pkt_rx_pkg::bus_bytes; i++)
			in_cnt = in_cnt + 3'(mid_tkeep[i]);

		for (int i = 0; i < pkt_rx_pkg::hdr_split_lanes; i++)
			res_masked[i*8 +: 8] = (i < res_cnt) ? res[i*8 +: 8] : 8'h00;

		total = {1'b0, res_cnt} + in_cnt;

		// New bytes land directly above whatever is already held.
		merged = ({{(pkt_rx_pkg::hdr_split_lanes*8){1'b0}}, in_aligned} << {res_cnt, 3'b000})
			| {{pkt_rx_pkg::bus_bits{1'b0}}, res_masked};

		for (int i = 0; i < pkt_rx_pkg::bus_bytes; i++)
		begin
			part_keep[i] = i < total;
			res_keep[i] = i < res_cnt;
		end
	end

	// -------------------------------------------------------------------------
	// Control state.
	// -------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			out_tvalid <= 1'b0;
			flush <= 1'b0;
			res_cnt <= '0;
		end
		else if (out_free)
		begin
			if (flush)
			begin
				out_tvalid <= 1'b1;
				flush <= 1'b0;
				res_cnt <= '0;
			end
			else if (mid_tvalid)
			begin
				// A beat goes out once a full word is available or the packet ends.
				out_tvalid <= (total >= pkt_rx_pkg::bus_bytes) || mid_tlast;
				flush <= mid_tlast && (total > pkt_rx_pkg::bus_bytes);
				if (total >= pkt_rx_pkg::bus_bytes)
					res_cnt <= 2'(total - 3'(pkt_rx_pkg::bus_bytes));
				else if (mid_tlast)
					res_cnt <= '0;
				else
					res_cnt <= total[1:0];
			end
			else
				out_tvalid <= 1'b0;
		end
	end

	// Data path, loaded only when the output register is free.
	always_ff @(posedge clk)
	begin
		if (out_free)
		begin
			if (flush)
			begin
				out_tdata <= {{(pkt_rx_pkg::bus_bits - pkt_rx_pkg::hdr_split_lanes*8){1'b0}},
					res_masked};
				out_tkeep <= res_keep;
				out_tlast <= 1'b1;
			end
			else if (mid_tvalid)
			begin
				out_tdata <= merged[pkt_rx_pkg::bus_bits-1:0];
				out_tkeep <= part_keep;
				out_tlast <= mid_tlast && (total <= pkt_rx_pkg::bus_bytes);
				if (total >= pkt_rx_pkg::bus_bytes)
					res <= merged[pkt_rx_pkg::bus_bits +: pkt_rx_pkg::hdr_split_lanes*8];
				else
					res <= merged[0 +: pkt_rx_pkg::hdr_split_lanes*8];
			end
		end
	end

	// A stalled beat must not change until the sink takes it.
	assert property (@(posedge clk) disable iff (!rst_n)
		out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata)
			&& $stable(out_tkeep) && $stable(out_tlast));

	assert property (@(posedge clk) disable iff (!rst_n)
		out_tvalid && !out_tlast |-> out_tkeep == '1);

endmodule

//--- logic/pkt_header_tagger.sv
// Removes the fixed header from each input packet and holds it on a side bus for the decoder.

`timescale 1ns/1ps

module pkt_header_tagger
(
	input logic clk,
	input logic rst_n,

	// Packed input stream.
	input logic in_tvalid,
	input logic in_tlast,
	input logic [pkt_rx_pkg::bus_bits-1:0] in_tdata,
	input logic [pkt_rx_pkg::bus_bytes-1:0] in_tkeep,
	output logic in_tready,

	// Payload stream, unpacked on the split word.
	output logic mid_tvalid,
	output logic mid_tlast,
	output logic [pkt_rx_pkg::bus_bits-1:0] mid_tdata,
	output logic [pkt_rx_pkg::bus_bytes-1:0] mid_tkeep,
	input logic mid_tready,

	output pkt_rx_pkg::hdr_u hdr
);

	// Word position within the current packet. It saturates once the
	// header has been passed, so payload words never touch the store.
	logic [$clog2(pkt_rx_pkg::hdr_words + 1)-1:0] ctr;
	logic in_fire;
	logic in_header;
	logic in_split;

	// The store is a whole number of bus words wide; only the low
	// header bytes are presented on hdr.
	logic [pkt_rx_pkg::hdr_words*pkt_rx_pkg::bus_bits-1:0] hdr_wide;

	assign in_fire = in_tvalid && in_tready;
	assign in_header = ctr < pkt_rx_pkg::hdr_words;
	assign in_split = ctr == pkt_rx_pkg::hdr_words - 1;

	always_ff @(posedge clk)
	begin
		if (!rst_n || (in_fire && in_tlast))
			ctr <= '0;
		else if (in_fire && in_header)
			ctr <= ctr + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (in_fire && in_header)
			hdr_wide[ctr*pkt_rx_pkg::bus_bits +: pkt_rx_pkg::bus_bits] <= in_tdata;
	end

	assign hdr = hdr_wide[pkt_rx_pkg::hdr_bytes*8-1:0];

	// -------------------------------------------------------------------------
	// Output side. Words made only of header bytes are taken at once and
	// dropped; from the split word on, the sink sets the pace.
	// -------------------------------------------------------------------------

	assign in_tready = (ctr < pkt_rx_pkg::hdr_words - 1) ? 1'b1 : mid_tready;
	assign mid_tvalid = (ctr < pkt_rx_pkg::hdr_words - 1) ? 1'b0 : in_tvalid;
	assign mid_tlast = in_tlast;
	assign mid_tdata = in_tdata;
	assign mid_tkeep = in_split ? (in_tkeep & pkt_rx_pkg::split_keep) : in_tkeep;

	// Only the final beat of a packet may be short on the input.
	assert property (@(posedge clk) disable iff (!rst_n)
		in_tvalid && !in_tlast |-> in_tkeep == '1);

endmodule

//--- logic/pkt_rx_pkg.sv
// Shared widths, header kinds and header layouts for the receive path; referenced by scoped name.

package pkt_rx_pkg;

	// -------------------------------------------------------------------------
	// Stream and header geometry.
	// -------------------------------------------------------------------------

	// Byte lanes on every stream link.
	localparam int bus_bytes = 4;
	localparam int bus_bits = bus_bytes * 8;

	// Header length and the number of bus words that carry header bytes.
	localparam int hdr_bytes = 6;
	localparam int hdr_words = (hdr_bytes + bus_bytes - 1) / bus_bytes;

	// The word that ends the header also carries the first payload bytes.
	localparam int hdr_split_lanes = hdr_words * bus_bytes - hdr_bytes;
	localparam int hdr_lanes = bus_bytes - hdr_split_lanes;

	// Keep mask for the split word, with the header lanes cleared.
	localparam logic [bus_bytes-1:0] split_keep = {{hdr_split_lanes{1'b1}}, {hdr_lanes{1'b0}}};

	// -------------------------------------------------------------------------
	// Header kinds and layouts.
	// -------------------------------------------------------------------------

	localparam logic [7:0] kind_route = 8'h01;
	localparam logic [7:0] kind_ctrl = 8'h02;

	// Route header. Header byte 0 is the least significant byte of the word,
	// so the multi-byte fields come out little-endian without any swapping.
	typedef struct packed {
		logic [15:0] length;
		logic [15:0] flow_id;
		logic [7:0] dest;
		logic [7:0] kind;
	} hdr_route_t;

	// Control header, same word, different meaning above the kind byte.
	typedef struct packed {
		logic [31:0] arg;
		logic [7:0] opcode;
		logic [7:0] kind;
	} hdr_ctrl_t;

	// One 48-bit header word, read as route or control depending on kind.
	typedef union packed {
		hdr_route_t route;
		hdr_ctrl_t ctrl;
	} hdr_u;

endpackage
